// ==== common/video_pkg.sv ====
`default_nettype none

package video_pkg;

	// ------------------------------------------------------------
	// pixel word
	// ------------------------------------------------------------

	localparam int pixel_w = 24;

	// one 24-bit word, read either as colour or as a gray byte
	// rgb keeps r in the low byte, b in the high byte
	typedef union packed {
		struct packed {
			logic [7:0] b;
			logic [7:0] g;
			logic [7:0] r;
		} rgb;
		struct packed {
			logic [pixel_w-9:0] pad;
			logic [7:0]         level;
		} gray;
	} pixel_word_t;

	// ------------------------------------------------------------
	// luma weights
	// ------------------------------------------------------------

	// weights add up to 256, so gray is the weighted sum shifted right by 8
	localparam logic [7:0] luma_r = 8'd77;
	localparam logic [7:0] luma_g = 8'd150;
	localparam logic [7:0] luma_b = 8'd29;

endpackage

`default_nettype wire

// ==== common/pattern_pkg.sv ====
`default_nettype none

package pattern_pkg;

	// ------------------------------------------------------------
	// pattern select
	// ------------------------------------------------------------

	localparam int mode_w = 2;

	localparam logic [mode_w-1:0] mode_index = 2'd0;
	localparam logic [mode_w-1:0] mode_ramp  = 2'd1;
	localparam logic [mode_w-1:0] mode_bars  = 2'd2;
	localparam logic [mode_w-1:0] mode_grid  = 2'd3;

	// ------------------------------------------------------------
	// pattern constants
	// ------------------------------------------------------------

	// colour bars left to right, packed as {b, g, r}
	localparam logic [23:0] bar_colors [8] = '{
		24'hffffff,
		24'h00ffff,
		24'hffff00,
		24'h00ff00,
		24'hff00ff,
		24'h0000ff,
		24'hff0000,
		24'h000000
	};

	localparam int grid_pitch = 16;

endpackage

`default_nettype wire

// ==== pattern_source/frame_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_timing #(
	parameter int X_NUM     = 64,
	parameter int Y_NUM     = 48,
	parameter int FRAME_GAP = 5
) (
	input  logic        aclk,
	input  logic        aresetn,

	input  logic        src_ready,
	output logic        src_valid,
	output logic [15:0] x,
	output logic [15:0] y,
	output logic        sof,
	output logic        eol
);

	localparam logic [15:0] x_last = 16'(X_NUM - 1);
	localparam logic [15:0] y_last = 16'(Y_NUM - 1);
	localparam logic [15:0] gap_len = 16'(FRAME_GAP);

	logic [15:0] gap_cnt;
	logic        accept;

	assign accept = src_valid && src_ready;

	// ------------------------------------------------------------
	// raster counters and inter-frame gap
	// ------------------------------------------------------------

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			x       <= '0;
			y       <= '0;
			gap_cnt <= '0;
		end else if (gap_cnt != '0) begin
			// idle between frames, counters already sit at 0,0
			gap_cnt <= gap_cnt - 16'd1;
		end else if (accept) begin
			if (eol) begin
				x <= '0;
				if (y == y_last) begin
					y       <= '0;
					gap_cnt <= gap_len;
				end else begin
					y <= y + 16'd1;
				end
			end else begin
				x <= x + 16'd1;
			end
		end
	end

	// the source is only idle while the gap runs
	assign src_valid = (gap_cnt == '0);

	assign sof = (x == '0) && (y == '0);
	assign eol = (x == x_last);

endmodule

`default_nettype wire

// ==== pattern_source/pattern_generator.sv ====
`timescale 1ns/1ns
`default_nettype none

module pattern_generator import video_pkg::*, pattern_pkg::*; #(
	parameter int X_NUM = 64
) (
	input  logic              aclk,
	input  logic              aresetn,

	input  logic [mode_w-1:0] mode,
	input  logic [15:0]       x,
	input  logic [15:0]       y,
	input  logic              sof,
	input  logic              src_valid,
	input  logic              src_ready,
	output pixel_word_t       src_pixel
);

	localparam logic [15:0] bar_w = 16'(X_NUM / 8);

	logic              accept;
	logic [mode_w-1:0] frame_mode;
	logic [mode_w-1:0] cur_mode;
	logic [23:0]       pix_cnt;
	logic [23:0]       cur_index;
	logic [15:0]       xy_sum;
	logic [15:0]       bar_idx;
	logic              on_grid;

	assign accept = src_valid && src_ready;

	// the first beat of a frame already uses the new mode
	assign cur_mode  = sof ? mode : frame_mode;
	assign cur_index = sof ? 24'd0 : pix_cnt;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			frame_mode <= mode_index;
			pix_cnt    <= '0;
		end else if (accept) begin
			if (sof) begin
				frame_mode <= mode;
			end
			pix_cnt <= cur_index + 24'd1;
		end
	end

	// ------------------------------------------------------------
	// pixel from coordinates
	// ------------------------------------------------------------

	assign xy_sum  = x + y;
	assign bar_idx = x / bar_w;
	assign on_grid = (x % 16'(grid_pitch) == '0) || (y % 16'(grid_pitch) == '0);

	always_comb begin
		src_pixel = '0;
		case (cur_mode)
			mode_index: src_pixel.rgb = cur_index;
			mode_ramp: begin
				src_pixel.rgb.r = xy_sum[7:0];
				src_pixel.rgb.g = xy_sum[7:0];
				src_pixel.rgb.b = xy_sum[7:0];
			end
			mode_bars:  src_pixel.rgb = bar_colors[bar_idx[2:0]];
			default:    src_pixel.rgb = on_grid ? '1 : '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/gray_convert.sv ====
`timescale 1ns/1ns
`default_nettype none

module gray_convert import video_pkg::*; (
	input  logic        aclk,
	input  logic        aresetn,

	input  logic        gray_en,

	input  logic        src_valid,
	input  pixel_word_t src_pixel,
	input  logic        sof,
	input  logic        eol,
	output logic        src_ready,

	output logic        m_tvalid,
	output pixel_word_t m_tdata,
	output logic        m_tuser,
	output logic        m_tlast,
	input  logic        m_tready
);

	logic        s1_valid;
	logic        s2_valid;
	logic        s1_en;
	logic        s2_en;

	// stage one payload
	pixel_word_t s1_pixel;
	logic [15:0] s1_pr;
	logic [15:0] s1_pg;
	logic [15:0] s1_pb;
	logic        s1_gray;
	logic        s1_sof;
	logic        s1_eol;

	logic [15:0] luma_sum;
	pixel_word_t gray_word;

	// ------------------------------------------------------------
	// stage enables
	// ------------------------------------------------------------

	// a stage moves when the one after it is empty or draining
	assign s2_en     = !s2_valid || m_tready;
	assign s1_en     = !s1_valid || s2_en;
	assign src_ready = s1_en;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (s1_en) s1_valid <= src_valid;
			if (s2_en) s2_valid <= s1_valid;
		end
	end

	// ------------------------------------------------------------
	// stage one, weighted products
	// ------------------------------------------------------------

	always_ff @(posedge aclk) begin
		if (s1_en && src_valid) begin
			s1_pixel <= src_pixel;
			s1_pr    <= {8'd0, src_pixel.rgb.r} * {8'd0, luma_r};
			s1_pg    <= {8'd0, src_pixel.rgb.g} * {8'd0, luma_g};
			s1_pb    <= {8'd0, src_pixel.rgb.b} * {8'd0, luma_b};
			s1_gray  <= gray_en;
			s1_sof   <= sof;
			s1_eol   <= eol;
		end
	end

	// ------------------------------------------------------------
	// stage two, sum and select
	// ------------------------------------------------------------

	// max sum is 255 * 256, fits in 16 bits
	assign luma_sum = s1_pr + s1_pg + s1_pb;

	always_comb begin
		gray_word            = '0;
		gray_word.gray.level = luma_sum[15:8];
	end

	always_ff @(posedge aclk) begin
		if (s2_en && s1_valid) begin
			m_tdata <= s1_gray ? gray_word : s1_pixel;
			m_tuser <= s1_sof;
			m_tlast <= s1_eol;
		end
	end

	assign m_tvalid = s2_valid;

endmodule

`default_nettype wire

// ==== verilog/video_pattern_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module video_pattern_top import video_pkg::*, pattern_pkg::*; #(
	parameter int X_NUM     = 64,
	parameter int Y_NUM     = 48,
	parameter int FRAME_GAP = 5
) (
	input  logic              aclk,
	input  logic              aresetn,

	input  logic [mode_w-1:0] mode,
	input  logic              gray_en,

	output logic              m_tvalid,
	output pixel_word_t       m_tdata,
	output logic              m_tuser,
	output logic              m_tlast,
	input  logic              m_tready
);

	logic        src_valid;
	logic        src_ready;
	logic [15:0] x;
	logic [15:0] y;
	logic        sof;
	logic        eol;
	pixel_word_t src_pixel;

	// ------------------------------------------------------------
	// raster and pattern source
	// ------------------------------------------------------------

	frame_timing #(
		.X_NUM     (X_NUM),
		.Y_NUM     (Y_NUM),
		.FRAME_GAP (FRAME_GAP)
	) i_frame_timing (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.src_ready (src_ready),
		.src_valid (src_valid),
		.x         (x),
		.y         (y),
		.sof       (sof),
		.eol       (eol)
	);

	pattern_generator #(
		.X_NUM     (X_NUM)
	) i_pattern_generator (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.mode      (mode),
		.x         (x),
		.y         (y),
		.sof       (sof),
		.src_valid (src_valid),
		.src_ready (src_ready),
		.src_pixel (src_pixel)
	);

	// ------------------------------------------------------------
	// optional gray stage, drives the output stream
	// ------------------------------------------------------------

	gray_convert i_gray_convert (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.gray_en   (gray_en),
		.src_valid (src_valid),
		.src_pixel (src_pixel),
		.sof       (sof),
		.eol       (eol),
		.src_ready (src_ready),
		.m_tvalid  (m_tvalid),
		.m_tdata   (m_tdata),
		.m_tuser   (m_tuser),
		.m_tlast   (m_tlast),
		.m_tready  (m_tready)
	);

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic aclk,
	output logic aresetn
);

	initial begin
		aclk = 1'b0;
		forever #(PERIOD_NS / 2) aclk = ~aclk;
	end

	// reset released on a rising edge, like every other input
	initial begin
		aresetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge aclk);
		aresetn <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== dv/video_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module video_checker import video_pkg::*, pattern_pkg::*; #(
	parameter int X_NUM     = 64,
	parameter int Y_NUM     = 48,
	parameter int FRAME_GAP = 5
) (
	input  logic              aclk,
	input  logic              aresetn,
	input  logic [mode_w-1:0] mode,
	input  logic              gray_en,
	input  logic              m_tvalid,
	input  logic              m_tready,
	input  pixel_word_t       m_tdata,
	input  logic              m_tuser,
	input  logic              m_tlast,
	output int                error_count,
	output int                beat_count,
	output int                frame_count
);

	int                px;
	int                py;
	int                idle_cnt;
	logic              in_gap;
	logic [mode_w-1:0] frame_mode;
	logic              frame_gray;
	pixel_word_t       exp_pixel;

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------

	// which of r, g, b are lit for each bar, left to right
	function automatic logic [2:0] bar_channels(input int bar);
		case (bar)
			0:       return 3'b111;
			1:       return 3'b110;
			2:       return 3'b011;
			3:       return 3'b010;
			4:       return 3'b101;
			5:       return 3'b100;
			6:       return 3'b001;
			default: return 3'b000;
		endcase
	endfunction

	function automatic pixel_word_t expected_rgb(input logic [mode_w-1:0] m, input int cx,
			input int cy);
		pixel_word_t p;
		logic [2:0]  lit;
		logic [7:0]  level;
		p = '0;
		case (m)
			mode_index: p = 24'(cy * X_NUM + cx);
			mode_ramp: begin
				level   = 8'(cx + cy);
				p.rgb.r = level;
				p.rgb.g = level;
				p.rgb.b = level;
			end
			mode_bars: begin
				lit     = bar_channels(cx / (X_NUM / 8));
				p.rgb.r = {8{lit[2]}};
				p.rgb.g = {8{lit[1]}};
				p.rgb.b = {8{lit[0]}};
			end
			default: begin
				if (cx % grid_pitch == 0 || cy % grid_pitch == 0)
					p = 24'hffffff;
			end
		endcase
		return p;
	endfunction

	function automatic pixel_word_t to_gray(input pixel_word_t p);
		pixel_word_t g;
		int          sum;
		sum = int'(luma_r) * int'(p.rgb.r) + int'(luma_g) * int'(p.rgb.g)
			+ int'(luma_b) * int'(p.rgb.b);
		g            = '0;
		g.gray.level = 8'(sum >> 8);
		return g;
	endfunction

	task automatic check_value(input string name, input logic [23:0] exp_val,
			input logic [23:0] act_val);
		if (exp_val !== act_val) begin
			error_count++;
			$display("error at %0t ns: %s expected %0h got %0h", $time, name, exp_val, act_val);
		end
	endtask

	// ------------------------------------------------------------
	// beat by beat comparison
	// ------------------------------------------------------------

	always @(posedge aclk) begin
		if (!aresetn) begin
			px          = 0;
			py          = 0;
			idle_cnt    = 0;
			in_gap      = 1'b0;
			error_count = 0;
			beat_count  = 0;
			frame_count = 0;
		end else begin
			if (in_gap) begin
				if (m_tvalid) begin
					if (idle_cnt < FRAME_GAP) begin
						error_count++;
						$display("error at %0t ns: m_tvalid idle gap expected at least %0d got %0d",
							$time, FRAME_GAP, idle_cnt);
					end
					in_gap = 1'b0;
				end else begin
					idle_cnt++;
				end
			end
			if (m_tvalid && m_tready) begin
				// inputs only move in the gap, so they still hold the frame's setting
				if (px == 0 && py == 0) begin
					frame_mode = mode;
					frame_gray = gray_en;
				end
				exp_pixel = expected_rgb(frame_mode, px, py);
				if (frame_gray)
					exp_pixel = to_gray(exp_pixel);
				check_value("m_tdata", exp_pixel, m_tdata);
				check_value("m_tuser", 24'(px == 0 && py == 0), 24'(m_tuser));
				check_value("m_tlast", 24'(px == X_NUM - 1), 24'(m_tlast));
				beat_count++;
				if (px == X_NUM - 1) begin
					px = 0;
					if (py == Y_NUM - 1) begin
						py       = 0;
						frame_count++;
						in_gap   = 1'b1;
						idle_cnt = 0;
					end else begin
						py++;
					end
				end else begin
					px++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/video_stream_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module video_stream_properties (
	input  logic        aclk,
	input  logic        aresetn,
	input  logic        m_tvalid,
	input  logic        m_tready,
	input  logic [23:0] m_tdata,
	input  logic        m_tuser,
	input  logic        m_tlast
);

	int failures = 0;

	// output stage is empty right after a reset edge
	reset_clears_valid: assert property (@(posedge aclk) !aresetn |=> !m_tvalid)
		else begin
			failures++;
			$error("m_tvalid high in the cycle after reset");
		end

	// a beat waiting for tready keeps its payload
	stall_holds_beat: assert property (@(posedge aclk) disable iff (!aresetn)
		m_tvalid && !m_tready |=>
			m_tvalid && $stable(m_tdata) && $stable(m_tuser) && $stable(m_tlast))
		else begin
			failures++;
			$error("stalled beat changed or was dropped before acceptance");
		end

	sof_not_eol: assert property (@(posedge aclk) disable iff (!aresetn)
		m_tvalid |-> !(m_tuser && m_tlast))
		else begin
			failures++;
			$error("m_tuser and m_tlast high on the same beat");
		end

endmodule

`default_nettype wire

// ==== dv/tb_video_pattern.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_video_pattern;

	localparam int x_num       = 64;
	localparam int y_num       = 48;
	localparam int frame_gap   = 5;
	localparam int frames      = 8;
	localparam int frame_beats = x_num * y_num;
	// four cycles per beat is far beyond the 70 percent tready rate
	localparam int timeout_cycles = frames * (frame_beats * 4 + frame_gap) + 2;

	logic        aclk;
	logic        aresetn;
	logic [1:0]  mode;
	logic        gray_en;
	logic        m_tready;
	logic        m_tvalid;
	logic [23:0] m_tdata;
	logic        m_tuser;
	logic        m_tlast;

	int          seed;
	int          frame_beat = 0;
	int          frames_done = 0;
	logic        gap_pending = 1'b0;
	logic [1:0]  mode_offset;
	logic        gray_offset;
	int          error_count;
	int          beat_count;
	int          frame_count;
	int          total_errors;

	tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(2)) i_tb_clock_gen (
		.aclk    (aclk),
		.aresetn (aresetn)
	);

	video_pattern_top #(
		.X_NUM     (x_num),
		.Y_NUM     (y_num),
		.FRAME_GAP (frame_gap)
	) i_video_pattern_top (
		.aclk     (aclk),
		.aresetn  (aresetn),
		.mode     (mode),
		.gray_en  (gray_en),
		.m_tvalid (m_tvalid),
		.m_tdata  (m_tdata),
		.m_tuser  (m_tuser),
		.m_tlast  (m_tlast),
		.m_tready (m_tready)
	);

	video_checker #(
		.X_NUM     (x_num),
		.Y_NUM     (y_num),
		.FRAME_GAP (frame_gap)
	) i_video_checker (
		.aclk        (aclk),
		.aresetn     (aresetn),
		.mode        (mode),
		.gray_en     (gray_en),
		.m_tvalid    (m_tvalid),
		.m_tready    (m_tready),
		.m_tdata     (m_tdata),
		.m_tuser     (m_tuser),
		.m_tlast     (m_tlast),
		.error_count (error_count),
		.beat_count  (beat_count),
		.frame_count (frame_count)
	);

	bind video_pattern_top video_stream_properties i_video_stream_properties (
		.aclk     (aclk),
		.aresetn  (aresetn),
		.m_tvalid (m_tvalid),
		.m_tready (m_tready),
		.m_tdata  (m_tdata),
		.m_tuser  (m_tuser),
		.m_tlast  (m_tlast)
	);

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------

	initial begin
		seed        = 32'h1d46;
		mode_offset = 2'($random(seed));
		gray_offset = 1'($random(seed));
		mode        = mode_offset;
		gray_en     = gray_offset;
		m_tready    = 1'b0;
	end

	always @(posedge aclk) begin : drive
		int beat_next;
		beat_next = frame_beat + ((m_tvalid && m_tready) ? 1 : 0);
		// step through all mode and gray combinations, one per frame
		if (gap_pending && !m_tvalid) begin
			mode        <= 2'(frames_done) + mode_offset;
			gray_en     <= 1'(frames_done >> 2) ^ gray_offset;
			gap_pending  = 1'b0;
		end
		if (beat_next == frame_beats) begin
			beat_next   = 0;
			frames_done++;
			gap_pending = 1'b1;
		end
		frame_beat = beat_next;
		// the last line runs unstalled so the source gap reaches the output
		if (beat_next >= frame_beats - x_num)
			m_tready <= 1'b1;
		else
			m_tready <= ({$random(seed)} % 10) < 7;
	end

	// ------------------------------------------------------------
	// end of run and watchdog
	// ------------------------------------------------------------

	initial begin : finish_run
		wait (aresetn && frame_count == frames);
		@(posedge aclk);
		total_errors = error_count + i_video_pattern_top.i_video_stream_properties.failures;
		$display("frames %0d beats %0d check errors %0d assertion errors %0d", frame_count,
			beat_count, error_count, i_video_pattern_top.i_video_stream_properties.failures);
		if (total_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin : watchdog
		repeat (timeout_cycles) @(posedge aclk);
		$display("timeout after %0d cycles with %0d of %0d frames received, %0d errors",
			timeout_cycles, frame_count, frames, error_count);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
common/video_pkg.sv
common/pattern_pkg.sv
pattern_source/frame_timing.sv
pattern_source/pattern_generator.sv
verilog/gray_convert.sv
verilog/video_pattern_top.sv
dv/tb_clock_gen.sv
dv/video_checker.sv
dv/video_stream_properties.sv
dv/tb_video_pattern.sv

// ==== Bender.yml ====
package:
  name: video_pattern

sources:
  - common/video_pkg.sv
  - common/pattern_pkg.sv
  - pattern_source/frame_timing.sv
  - pattern_source/pattern_generator.sv
  - verilog/gray_convert.sv
  - verilog/video_pattern_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/video_checker.sv
      - dv/video_stream_properties.sv
      - dv/tb_video_pattern.sv
